// ==== build.f ====
rtl/chiplet_tx_pkg.sv
rtl/tx_apb_regs.sv
rtl/tx_pkt_mem.sv
rtl/pkt_hdr_decode.sv
rtl/tx_fsm.sv
rtl/flit_queue.sv
rtl/chiplet_tx_top.sv
testbench/tb_chiplet_tx.sv

// ==== testbench/tb_chiplet_tx.sv ====
`timescale 1ns/1ps

module tb_chiplet_tx;
    import chiplet_tx_pkg::*;

    // fill 520 + two format passes of about 500 and 1100 cycles + small tests, with margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] LFSR_SEED = 32'hb52f_098a;

    logic clk, n_rst, psel, penable, pwrite, flit_ready, pready, pslverr, flit_valid, bp_on;
    logic [11:0] paddr;
    logic [31:0] pwdata, prdata, lfsr;
    flit_t       flit;
    logic [39:0] exp_q [$];
    logic [39:0] exp_flit;
    logic [31:0] mem_model [256];
    logic [3:0]  node_val = 4'h9;
    string       test_name = "setup";
    int reg_errs = 0, flit_errs = 0, stab_errs = 0, errs_before = 0;
    int pass_count = 0, fail_count = 0, sent_model = 0, cycles = 0;

    chiplet_tx_top uut (
        .clk (clk), .n_rst (n_rst), .psel (psel), .penable (penable), .pwrite (pwrite),
        .paddr (paddr), .pwdata (pwdata), .flit_ready (flit_ready), .prdata (prdata),
        .pready (pready), .pslverr (pslverr), .flit_valid (flit_valid), .flit (flit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a, ~a, a ^ 8'h3c, 8'(a * 7 + 1)};
    endfunction

    function automatic int expected_length(input logic [31:0] hdr);
        int data_long;
        int data_short;
        data_long  = (hdr[7:0] == 8'd0) ? 128 : int'(hdr[7:0]);
        data_short = (hdr[3:0] == 4'd0) ? 16 : int'(hdr[3:0]);
        case (hdr[31:28])
            4'd1: return 3;
            4'd2: return 3 + data_long;
            4'd3, 4'd4: return 2 + data_long;
            4'd6: return 2;
            4'd7: return 2 + data_short;
            default: return 1; // switch cfg and unknown formats
        endcase
    endfunction

    // one bit of the lfsr per cycle while back-pressure is on
    initial begin
        flit_ready = 1'b0;
        lfsr = LFSR_SEED;
        forever begin
            @(posedge clk);
            #2;
            if (bp_on) begin
                lfsr = lfsr_step(lfsr);
                flit_ready = lfsr[0];
            end else begin
                flit_ready = 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (n_rst && flit_valid && flit_ready) begin
            if (exp_q.size() == 0) begin
                flit_errs++;
                $display("Unexpected flit %h in %s with no flit outstanding", flit, test_name);
            end else begin
                exp_flit = exp_q.pop_front();
                assert (flit === exp_flit) else begin
                    flit_errs++;
                    $display("Mismatch %s flit expected %h actual %h", test_name, exp_flit, flit);
                end
            end
        end
    end

    assert property (@(negedge clk) disable iff (!n_rst)
        flit_valid && !flit_ready |=> flit_valid && $stable(flit))
    else begin
        stab_errs++;
        $display("Flit changed or dropped while stalled in %s", test_name);
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles in %s, packets did not complete", cycles, test_name);
        $display("Test FAILED");
        $finish;
    end

    task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            reg_errs++;
            $display("Mismatch %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // caller sits 2 ns after a rising edge
    task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                              output logic [31:0] rdata, output logic err);
        psel = 1'b1;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err = pslverr;
        check("pready", 32'd1, 32'(pready)); // zero wait states
        @(posedge clk);
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic err;
        apb_access(1'b1, addr, data, rdata, err);
        check("pslverr on write", 32'd0, 32'(err));
        if (addr[11:10] == 2'b01) begin
            mem_model[addr[9:2]] = data;
        end
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] expected);
        logic [31:0] rdata;
        logic err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        check($sformatf("read %h", addr), expected, rdata);
        check("pslverr on read", 32'd0, 32'(err));
    endtask

    task automatic queue_packet(input int slot, input logic [7:0] start, input logic [31:0] hdr);
        int len;
        apb_write(REG_START0 + 12'(slot * 4), 32'(start));
        apb_write(MEM_BASE + {2'b00, start, 2'b00}, hdr);
        len = expected_length(hdr);
        for (int k = 0; k < len; k++) begin
            exp_q.push_back({2'b00, 2'(slot), node_val, mem_model[8'(int'(start) + k)]});
        end
        sent_model++;
    endtask

    task automatic trigger_and_drain(input logic [3:0] mask);
        apb_write(REG_TRIGGER, 32'(mask));
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // room for any extra flit to show up
        #2;
    endtask

    task automatic run_formats(input logic zero_len);
        logic [3:0] fmts [8] = '{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'hc};
        for (int i = 0; i < 8; i++) begin
            queue_packet(i % 4, 8'h20,
                         {fmts[i], 20'h5a3c1, zero_len ? 8'd0 : 8'(i * 3 + 2)});
            trigger_and_drain(4'(1 << (i % 4)));
        end
    endtask

    task automatic end_test();
        int now_errs;
        now_errs = reg_errs + flit_errs + stab_errs;
        if (now_errs == errs_before) begin
            pass_count++;
            $display("%s passed", test_name);
        end else begin
            fail_count++;
            $display("%s failed with %0d errors", test_name, now_errs - errs_before);
        end
        errs_before = now_errs;
    endtask

    initial begin
        logic [31:0] rdata;
        logic err;
        n_rst = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        bp_on = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        n_rst = 1'b1;

        test_name = "reset_and_registers";
        @(negedge clk);
        check("flit_valid", 32'd0, 32'(flit_valid));
        @(posedge clk);
        #2;
        read_check(REG_NODE_ID, 32'd0);
        read_check(REG_TRIGGER, 32'd0);
        read_check(REG_SENT, 32'd0);
        apb_write(REG_NODE_ID, 32'(node_val));
        read_check(REG_NODE_ID, 32'(node_val));
        for (int s = 0; s < 4; s++) begin
            apb_write(REG_START0 + 12'(s * 4), 32'(8'h11 * (s + 1)));
            read_check(REG_START0 + 12'(s * 4), 32'(8'h11 * (s + 1)));
        end
        apb_access(1'b0, 12'h020, 32'd0, rdata, err);
        check("pslverr unmapped", 32'd1, 32'(err));
        apb_access(1'b1, REG_SENT, 32'h55, rdata, err);
        check("pslverr sent write", 32'd1, 32'(err));
        end_test();

        for (int a = 0; a < 256; a++) begin
            apb_write(MEM_BASE + 12'(a * 4), fill_word(8'(a)));
        end

        test_name = "all_formats";
        run_formats(1'b0);
        run_formats(1'b1);
        read_check(REG_SENT, 32'(sent_model));
        end_test();

        test_name = "back_pressure";
        bp_on = 1'b1;
        run_formats(1'b0);
        run_formats(1'b1);
        bp_on = 1'b0;
        end_test();

        test_name = "slot_priority";
        queue_packet(1, 8'h40, {4'd7, 20'h0, 8'h04});
        queue_packet(2, 8'h50, {4'd1, 20'h0, 8'h00});
        queue_packet(3, 8'h60, {4'd4, 20'h0, 8'h02});
        trigger_and_drain(4'b1110); // lowest slot goes first
        read_check(REG_TRIGGER, 32'd0);
        end_test();

        test_name = "sent_count_and_wrap";
        read_check(REG_SENT, 32'(sent_model));
        queue_packet(0, 8'hfa, {4'd4, 20'h0, 8'h0a}); // 12 words, wraps past 255
        trigger_and_drain(4'b0001);
        read_check(REG_SENT, 32'(sent_model));
        end_test();

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && reg_errs + flit_errs + stab_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/chiplet_tx_top.sv ====
`timescale 1ns/1ps

module chiplet_tx_top (
    input  logic                                  clk,
    input  logic                                  n_rst,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [chiplet_tx_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [31:0]                           pwdata,
    input  logic                                  flit_ready,
    output logic [31:0]                           prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output logic                                  flit_valid,
    output chiplet_tx_pkg::flit_t                 flit
);
    import chiplet_tx_pkg::*;

    logic [NUM_MSGS-1:0]                 pending;
    logic [NUM_MSGS-1:0][MEM_ADDR_W-1:0] start_addr;
    logic [NODE_ID_W-1:0]                node_id;
    logic                                start_pulse;
    logic [PKT_ID_W-1:0]                 start_id;
    logic                                pkt_done;
    logic                                mem_we;
    logic [MEM_ADDR_W-1:0]               mem_waddr;
    logic [31:0]                         mem_wdata;
    logic                                rd_en;
    logic [MEM_ADDR_W-1:0]               rd_addr;
    logic [31:0]                         rd_data;
    logic                                push;
    flit_t                               push_flit;
    logic [FREE_W-1:0]                   free_slots;

    tx_apb_regs u_regs (
        .clk         (clk),
        .n_rst       (n_rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .start_pulse (start_pulse),
        .start_id    (start_id),
        .pkt_done    (pkt_done),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .pending     (pending),
        .start_addr  (start_addr),
        .node_id     (node_id),
        .mem_we      (mem_we),
        .mem_waddr   (mem_waddr),
        .mem_wdata   (mem_wdata)
    );

    tx_pkt_mem u_mem (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    tx_fsm u_fsm (
        .clk         (clk),
        .n_rst       (n_rst),
        .pending     (pending),
        .start_addr  (start_addr),
        .node_id     (node_id),
        .rd_data     (rd_data),
        .free_slots  (free_slots),
        .start_pulse (start_pulse),
        .start_id    (start_id),
        .pkt_done    (pkt_done),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .push        (push),
        .push_flit   (push_flit)
    );

    flit_queue u_queue (
        .clk        (clk),
        .n_rst      (n_rst),
        .push       (push),
        .push_flit  (push_flit),
        .flit_ready (flit_ready),
        .free_slots (free_slots),
        .flit_valid (flit_valid),
        .flit       (flit)
    );

endmodule

// ==== rtl/flit_queue.sv ====
`timescale 1ns/1ps

module flit_queue (
    input  logic                              clk,
    input  logic                              n_rst,
    input  logic                              push,
    input  chiplet_tx_pkg::flit_t             push_flit,
    input  logic                              flit_ready,
    output logic [chiplet_tx_pkg::FREE_W-1:0] free_slots,
    output logic                              flit_valid,
    output chiplet_tx_pkg::flit_t             flit
);
    import chiplet_tx_pkg::*;

    flit_t             q [FLIT_DEPTH];
    logic [PTR_W-1:0]  wr_ptr, rd_ptr;
    logic [FREE_W-1:0] count;
    logic              pop;
    logic              do_push;

    assign flit_valid = (count != '0);
    assign flit       = q[rd_ptr];
    assign free_slots = FREE_W'(FLIT_DEPTH) - count;

    assign pop     = flit_valid && flit_ready;
    assign do_push = push && ((count != FREE_W'(FLIT_DEPTH)) || pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            q[wr_ptr] <= push_flit;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + PTR_W'(1); // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count <= count + FREE_W'(do_push) - FREE_W'(pop);
        end
    end

endmodule

// ==== rtl/tx_fsm.sv ====
`timescale 1ns/1ps

module tx_fsm (
    input  logic                                 clk,
    input  logic                                 n_rst,
    input  logic [chiplet_tx_pkg::NUM_MSGS-1:0]  pending,
    input  logic [chiplet_tx_pkg::NUM_MSGS-1:0][chiplet_tx_pkg::MEM_ADDR_W-1:0] start_addr,
    input  logic [chiplet_tx_pkg::NODE_ID_W-1:0] node_id,
    input  logic [31:0]                          rd_data,
    input  logic [chiplet_tx_pkg::FREE_W-1:0]    free_slots,
    output logic                                 start_pulse,
    output logic [chiplet_tx_pkg::PKT_ID_W-1:0]  start_id,
    output logic                                 pkt_done,
    output logic                                 rd_en,
    output logic [chiplet_tx_pkg::MEM_ADDR_W-1:0] rd_addr,
    output logic                                 push,
    output chiplet_tx_pkg::flit_t                push_flit
);
    import chiplet_tx_pkg::*;

    typedef enum logic [1:0] {
        IDLE, FETCH_HDR, DECODE, SEND
    } state_e;

    state_e              state, next_state;
    logic [PKT_ID_W-1:0] cur_id;
    logic [LENGTH_W-1:0] pkt_len, len_q;
    logic [LENGTH_W-1:0] rd_cnt, push_cnt;
    logic [FREE_W-1:0]   in_flight;
    logic                issue;

    pkt_hdr_decode u_decode (
        .hdr_word (rd_data),
        .pkt_len  (pkt_len)
    );

    // lowest pending slot wins
    always_comb begin
        start_id = '0;
        for (int i = NUM_MSGS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                start_id = PKT_ID_W'(i);
            end
        end
    end

    assign start_pulse = (state == IDLE) && (|pending);

    assign issue    = (state == SEND) && (rd_cnt != len_q) && (free_slots > in_flight);
    assign rd_en    = (state == FETCH_HDR) || issue;
    assign rd_addr  = start_addr[cur_id] + rd_cnt; // wraps mod 256
    assign pkt_done = push && (push_cnt == len_q - LENGTH_W'(1));

    assign push_flit.vc      = 2'b00;
    assign push_flit.id      = cur_id;
    assign push_flit.req     = node_id;
    assign push_flit.payload = rd_data;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (start_pulse) next_state = FETCH_HDR;
            FETCH_HDR: next_state = DECODE;
            DECODE:    next_state = SEND;
            SEND:      if (pkt_done) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state     <= IDLE;
            cur_id    <= '0;
            len_q     <= '0;
            rd_cnt    <= '0;
            push_cnt  <= '0;
            in_flight <= '0;
            push      <= 1'b0;
        end else begin
            state     <= next_state;
            push      <= issue; // data back one cycle after the read
            in_flight <= in_flight + FREE_W'(issue) - FREE_W'(push);
            if (start_pulse) begin
                cur_id <= start_id;
            end
            if (state == IDLE) begin
                rd_cnt   <= '0;
                push_cnt <= '0;
            end
            if (state == DECODE) begin
                len_q <= pkt_len; // header word is on rd_data here
            end
            if (issue) begin
                rd_cnt <= rd_cnt + LENGTH_W'(1);
            end
            if (push) begin
                push_cnt <= push_cnt + LENGTH_W'(1);
            end
        end
    end

endmodule

// ==== rtl/pkt_hdr_decode.sv ====
`timescale 1ns/1ps

module pkt_hdr_decode (
    input  logic [31:0]                         hdr_word,
    output logic [chiplet_tx_pkg::LENGTH_W-1:0] pkt_len
);
    import chiplet_tx_pkg::*;

    fmt_e                   fmt;
    logic [LONG_LEN_W-1:0]  long_len;
    logic [SHORT_LEN_W-1:0] short_len;
    logic [LENGTH_W-1:0]    long_data;
    logic [LENGTH_W-1:0]    short_data;

    assign fmt       = fmt_e'(hdr_word[FMT_MSB:FMT_LSB]);
    assign long_len  = hdr_word[LONG_LEN_W-1:0];
    assign short_len = hdr_word[SHORT_LEN_W-1:0];

    // zero length field means the maximum
    assign long_data  = (long_len == '0) ? LENGTH_W'(LONG_MAX) : LENGTH_W'(long_len);
    assign short_data = (short_len == '0) ? LENGTH_W'(SHORT_MAX) : LENGTH_W'(short_len);

    always_comb begin
        case (fmt)
            FMT_LONG_READ: begin
                pkt_len = LENGTH_W'(3); // hdr + addr + crc
            end
            FMT_LONG_WRITE: begin
                pkt_len = LENGTH_W'(3) + long_data;
            end
            FMT_MEM_RESP, FMT_MSG: begin
                pkt_len = LENGTH_W'(2) + long_data; // hdr + crc + data
            end
            FMT_SHORT_READ: begin
                pkt_len = LENGTH_W'(2);
            end
            FMT_SHORT_WRITE: begin
                pkt_len = LENGTH_W'(2) + short_data;
            end
            default: begin
                pkt_len = LENGTH_W'(1); // switch cfg and unknown formats
            end
        endcase
    end

endmodule

// ==== rtl/tx_pkt_mem.sv ====
`timescale 1ns/1ps

module tx_pkt_mem (
    input  logic                                  clk,
    input  logic                                  mem_we,
    input  logic [chiplet_tx_pkg::MEM_ADDR_W-1:0] mem_waddr,
    input  logic [31:0]                           mem_wdata,
    input  logic                                  rd_en,
    input  logic [chiplet_tx_pkg::MEM_ADDR_W-1:0] rd_addr,
    output logic [31:0]                           rd_data
);
    import chiplet_tx_pkg::*;

    logic [31:0] mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // holds last word until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== rtl/tx_apb_regs.sv ====
`timescale 1ns/1ps

module tx_apb_regs (
    input  logic                                     clk,
    input  logic                                     n_rst,
    input  logic                                     psel,
    input  logic                                     penable,
    input  logic                                     pwrite,
    input  logic [chiplet_tx_pkg::APB_ADDR_W-1:0]    paddr,
    input  logic [31:0]                              pwdata,
    input  logic                                     start_pulse,
    input  logic [chiplet_tx_pkg::PKT_ID_W-1:0]      start_id,
    input  logic                                     pkt_done,
    output logic [31:0]                              prdata,
    output logic                                     pready,
    output logic                                     pslverr,
    output logic [chiplet_tx_pkg::NUM_MSGS-1:0]      pending,
    output logic [chiplet_tx_pkg::NUM_MSGS-1:0][chiplet_tx_pkg::MEM_ADDR_W-1:0] start_addr,
    output logic [chiplet_tx_pkg::NODE_ID_W-1:0]     node_id,
    output logic                                     mem_we,
    output logic [chiplet_tx_pkg::MEM_ADDR_W-1:0]    mem_waddr,
    output logic [31:0]                              mem_wdata
);
    import chiplet_tx_pkg::*;

    logic                access;
    logic                wr;
    logic                aligned;
    logic                is_node, is_trig, is_sent, is_start, is_mem;
    logic                mapped;
    logic [PKT_ID_W-1:0] start_sel;
    logic [31:0]         sent_cnt;

    assign access  = psel && penable;
    assign wr      = access && pwrite;
    assign aligned = (paddr[1:0] == 2'b00);

    assign is_node  = aligned && (paddr == REG_NODE_ID);
    assign is_trig  = aligned && (paddr == REG_TRIGGER);
    assign is_sent  = aligned && (paddr == REG_SENT);
    assign is_start = aligned && (paddr[APB_ADDR_W-1:4] == REG_START0[APB_ADDR_W-1:4]);
    assign is_mem   = aligned && (paddr[APB_ADDR_W-1:10] == MEM_BASE[APB_ADDR_W-1:10]);
    assign mapped   = is_node || is_trig || is_sent || is_start || is_mem;

    assign start_sel = paddr[3:2]; // slot index within the start block

    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && is_sent));

    // memory window goes straight through
    assign mem_we    = wr && is_mem;
    assign mem_waddr = paddr[MEM_ADDR_W+1:2];
    assign mem_wdata = pwdata;

    always_comb begin
        prdata = '0;
        if (is_node) begin
            prdata = 32'(node_id);
        end else if (is_trig) begin
            prdata = 32'(pending);
        end else if (is_sent) begin
            prdata = sent_cnt;
        end else if (is_start) begin
            prdata = 32'(start_addr[start_sel]);
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            node_id    <= '0;
            start_addr <= '0;
        end else if (wr) begin
            if (is_node) begin
                node_id <= pwdata[NODE_ID_W-1:0];
            end
            if (is_start) begin
                start_addr[start_sel] <= pwdata[MEM_ADDR_W-1:0];
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= '0;
        end else begin
            for (int i = 0; i < NUM_MSGS; i++) begin
                if (wr && is_trig && pwdata[i]) begin
                    pending[i] <= 1'b1; // set beats clear
                end else if (start_pulse && (start_id == PKT_ID_W'(i))) begin
                    pending[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sent_cnt <= '0;
        end else if (pkt_done) begin
            sent_cnt <= sent_cnt + 32'd1;
        end
    end

endmodule

// ==== rtl/chiplet_tx_pkg.sv ====
package chiplet_tx_pkg;

    localparam int NUM_MSGS   = 4;
    localparam int PKT_ID_W   = 2;
    localparam int NODE_ID_W  = 4;
    localparam int MEM_WORDS  = 256;
    localparam int MEM_ADDR_W = 8;
    localparam int LENGTH_W   = 8;   // longest packet is 131 words
    localparam int FLIT_DEPTH = 4;
    localparam int FREE_W     = $clog2(FLIT_DEPTH + 1);
    localparam int PTR_W      = $clog2(FLIT_DEPTH);

    // header layout
    localparam int FMT_MSB     = 31;
    localparam int FMT_LSB     = 28;
    localparam int LONG_LEN_W  = 8;  // bits 7..0
    localparam int SHORT_LEN_W = 4;  // bits 3..0
    localparam int LONG_MAX    = 128;
    localparam int SHORT_MAX   = 16;

    typedef enum logic [3:0] {
        FMT_LONG_READ   = 4'd1,
        FMT_LONG_WRITE  = 4'd2,
        FMT_MEM_RESP    = 4'd3,
        FMT_MSG         = 4'd4,
        FMT_SWITCH_CFG  = 4'd5,
        FMT_SHORT_READ  = 4'd6,
        FMT_SHORT_WRITE = 4'd7
    } fmt_e;

    typedef struct packed {
        logic [1:0]           vc;
        logic [PKT_ID_W-1:0]  id;
        logic [NODE_ID_W-1:0] req;
        logic [31:0]          payload;
    } flit_t;

    // APB byte addresses
    localparam int APB_ADDR_W = 12;

    localparam logic [APB_ADDR_W-1:0] REG_NODE_ID = 12'h000;
    localparam logic [APB_ADDR_W-1:0] REG_TRIGGER = 12'h004;
    localparam logic [APB_ADDR_W-1:0] REG_SENT    = 12'h008;
    localparam logic [APB_ADDR_W-1:0] REG_START0  = 12'h010;
    localparam logic [APB_ADDR_W-1:0] MEM_BASE    = 12'h400;

endpackage
